// File: hw/ntm_fixed_pkg.sv
`default_nettype none

// Fixed-point widths and series length
// Modules take these only as parameter defaults
package ntm_fixed_pkg;

  ////////////////////////////////////////
  // Word format
  ////////////////////////////////////////

  // Full word width of every data path
  localparam int DEFAULT_DATA_SIZE = 32;

  // Fraction bits of the unsigned fixed-point format
  localparam int DEFAULT_FRAC_SIZE = 16;

  ////////////////////////////////////////
  // Series
  ////////////////////////////////////////

  // Odd terms kept from the sinh Taylor series
  // x + x^3/3! + x^5/5! + x^7/7!
  localparam int DEFAULT_SERIES_TERMS = 4;

endpackage

`default_nettype wire

// File: hw/ntm_ctrl_pkg.sv
`default_nettype none

// Controller state encodings
package ntm_ctrl_pkg;

  ////////////////////////////////////////
  // Vector element loop
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    STARTER = 2'd0,  // Waiting for start and a length
    INPUT   = 2'd1,  // Waiting for the next element strobe
    ENDER   = 2'd2   // Waiting for the scalar result
  } vector_state_t;

  ////////////////////////////////////////
  // Scalar series sequencer
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    SQUARE     = 3'd1,  // x2 = x * x
    MULTIPLY   = 3'd2,  // term * x2
    DIVIDE     = 3'd3,  // Divide by (2k)(2k+1)
    ACCUMULATE = 3'd4,
    REDUCE     = 3'd5,  // sum mod modulo
    DONE       = 3'd6
  } scalar_state_t;

endpackage

`default_nettype wire

// File: hw/ntm_arith_ifs.sv
`timescale 1ns/10ps
`default_nettype none

// Sequential multiplier port bundle
interface ntm_multiply_if import ntm_fixed_pkg::*; #(
  parameter int DATA_SIZE = DEFAULT_DATA_SIZE
);
  logic                 start;
  logic                 ready;
  logic [DATA_SIZE-1:0] multiplicand;
  logic [DATA_SIZE-1:0] multiplier;
  logic [DATA_SIZE-1:0] product;

  modport requester(output start, multiplicand, multiplier, input ready, product);
  modport unit(input start, multiplicand, multiplier, output ready, product);
endinterface

// Sequential divider port bundle
interface ntm_divide_if import ntm_fixed_pkg::*; #(
  parameter int DATA_SIZE = DEFAULT_DATA_SIZE
);
  logic                 start;
  logic                 ready;
  logic [DATA_SIZE-1:0] dividend;
  logic [DATA_SIZE-1:0] divisor;
  logic [DATA_SIZE-1:0] quotient;
  logic [DATA_SIZE-1:0] remainder;

  modport requester(output start, dividend, divisor, input ready, quotient, remainder);
  modport unit(input start, dividend, divisor, output ready, quotient, remainder);
endinterface

`default_nettype wire

// File: hw/ntm_fixed_multiplier.sv
`timescale 1ns/10ps
`default_nettype none

module ntm_fixed_multiplier import ntm_fixed_pkg::*; #(
  parameter int DATA_SIZE = DEFAULT_DATA_SIZE,
  parameter int FRAC_SIZE = DEFAULT_FRAC_SIZE
) (
  input logic          CLK,
  input logic          RST,
  ntm_multiply_if.unit mul
);

  localparam int CNT_W = $clog2(DATA_SIZE);
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(DATA_SIZE - 1);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  logic                   busy;
  logic [CNT_W-1:0]       step;
  // Double width running sum of partial products
  logic [2*DATA_SIZE-1:0] acc;
  // Multiplicand shifted left once per step
  logic [2*DATA_SIZE-1:0] addend;
  // Multiplier bits consumed LSB first
  logic [DATA_SIZE-1:0]   bits;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy      <= 1'b0;
      step      <= '0;
      mul.ready <= 1'b0;
    end else begin
      mul.ready <= 1'b0;
      if (mul.start) begin
        busy <= 1'b1;
        step <= '0;
      end else if (busy) begin
        step <= step + 1'b1;
        // Last partial product lands on this edge
        if (step == LAST_STEP) begin
          busy      <= 1'b0;
          mul.ready <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Shift-add datapath
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (mul.start) begin
      acc    <= '0;
      addend <= {{DATA_SIZE{1'b0}}, mul.multiplicand};
      bits   <= mul.multiplier;
    end else if (busy) begin
      if (bits[0]) begin
        acc <= acc + addend;
      end
      addend <= addend << 1;
      bits   <= bits >> 1;
    end
  end

  // Drop the fraction bits of the double width product
  assign mul.product = acc[FRAC_SIZE +: DATA_SIZE];

  // Requester must not restart while a result is being signalled
  a_no_ready_on_start: assert property (@(posedge CLK) disable iff (RST)
    mul.start |-> !mul.ready)
    else $error("multiplier ready high in start cycle");

endmodule

`default_nettype wire

// File: hw/ntm_fixed_divider.sv
`timescale 1ns/10ps
`default_nettype none

module ntm_fixed_divider import ntm_fixed_pkg::*; #(
  parameter int DATA_SIZE = DEFAULT_DATA_SIZE
) (
  input logic        CLK,
  input logic        RST,
  ntm_divide_if.unit div
);

  localparam int CNT_W = $clog2(DATA_SIZE);
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(DATA_SIZE - 1);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  logic                 busy;
  logic [CNT_W-1:0]     step;
  logic [DATA_SIZE-1:0] divisor_q;
  // Dividend shifts out the top while quotient bits shift in
  logic [DATA_SIZE-1:0] quot_q;
  logic [DATA_SIZE-1:0] rem_q;
  // Partial remainder with the next dividend bit appended
  logic [DATA_SIZE:0]   trial;
  logic [DATA_SIZE:0]   diff;
  logic                 fits;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy      <= 1'b0;
      step      <= '0;
      div.ready <= 1'b0;
    end else begin
      div.ready <= 1'b0;
      if (div.start) begin
        busy <= 1'b1;
        step <= '0;
      end else if (busy) begin
        step <= step + 1'b1;
        if (step == LAST_STEP) begin
          busy      <= 1'b0;
          div.ready <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Restoring division step
  ////////////////////////////////////////

  assign trial = {rem_q, quot_q[DATA_SIZE-1]};
  assign diff  = trial - {1'b0, divisor_q};
  assign fits  = (trial >= {1'b0, divisor_q});

  always_ff @(posedge CLK) begin
    if (div.start) begin
      divisor_q <= div.divisor;
      quot_q    <= div.dividend;
      rem_q     <= '0;
    end else if (busy) begin
      if (fits) begin
        rem_q  <= diff[DATA_SIZE-1:0];
        quot_q <= {quot_q[DATA_SIZE-2:0], 1'b1};
      end else begin
        // Restore by keeping the unsubtracted value
        rem_q  <= trial[DATA_SIZE-1:0];
        quot_q <= {quot_q[DATA_SIZE-2:0], 1'b0};
      end
    end
  end

  assign div.quotient  = quot_q;
  assign div.remainder = rem_q;

  // Series divisors and the host modulus must both be nonzero
  a_divisor_nonzero: assert property (@(posedge CLK) disable iff (RST)
    div.start |-> (div.divisor != '0))
    else $error("divider started with zero divisor");

endmodule

`default_nettype wire

// File: hw/ntm_scalar_sinh_function.sv
`timescale 1ns/10ps
`default_nettype none

module ntm_scalar_sinh_function
  import ntm_fixed_pkg::*;
  import ntm_ctrl_pkg::*;
#(
  parameter int DATA_SIZE    = DEFAULT_DATA_SIZE,
  parameter int FRAC_SIZE    = DEFAULT_FRAC_SIZE,
  parameter int SERIES_TERMS = DEFAULT_SERIES_TERMS
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  output logic                 ready,
  input  logic [DATA_SIZE-1:0] modulo_in,
  input  logic [DATA_SIZE-1:0] data_in,
  output logic [DATA_SIZE-1:0] data_out,
  ntm_multiply_if.requester    mul,
  ntm_divide_if.requester      div
);

  localparam int K_W = $clog2(SERIES_TERMS + 1);
  localparam logic [K_W-1:0] LAST_K = K_W'(SERIES_TERMS - 1);

  // Fraction must leave room for integer bits
  if (FRAC_SIZE >= DATA_SIZE || SERIES_TERMS < 1) begin : g_bad_params
    $error("ntm_scalar_sinh_function parameter out of range");
  end

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  scalar_state_t        state;
  // Current odd term index
  logic [K_W-1:0]       k;
  logic [DATA_SIZE-1:0] k_word;
  // (2k)(2k+1) as integer divisor
  logic [DATA_SIZE-1:0] series_div;

  logic [DATA_SIZE-1:0] x;
  logic [DATA_SIZE-1:0] x2;
  logic [DATA_SIZE-1:0] term;
  logic [DATA_SIZE-1:0] sum;
  logic [DATA_SIZE-1:0] modulo;

  assign k_word     = DATA_SIZE'(k);
  assign series_div = (k_word << 1) * ((k_word << 1) + 1'b1);

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= IDLE;
      k         <= '0;
      mul.start <= 1'b0;
      div.start <= 1'b0;
    end else begin
      // Unit starts are single cycle pulses
      mul.start <= 1'b0;
      div.start <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            mul.start <= 1'b1;
            state     <= SQUARE;
          end
        end
        SQUARE: begin
          if (mul.ready) begin
            k <= K_W'(1);
            if (SERIES_TERMS > 1) begin
              mul.start <= 1'b1;
              state     <= MULTIPLY;
            end else begin
              // Only x itself so go straight to reduction
              div.start <= 1'b1;
              state     <= REDUCE;
            end
          end
        end
        MULTIPLY: begin
          if (mul.ready) begin
            div.start <= 1'b1;
            state     <= DIVIDE;
          end
        end
        DIVIDE: begin
          if (div.ready) begin
            state <= ACCUMULATE;
          end
        end
        ACCUMULATE: begin
          if (k == LAST_K) begin
            div.start <= 1'b1;
            state     <= REDUCE;
          end else begin
            k         <= k + 1'b1;
            mul.start <= 1'b1;
            state     <= MULTIPLY;
          end
        end
        REDUCE: begin
          if (div.ready) begin
            state <= DONE;
          end
        end
        DONE: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Series datapath
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    case (state)
      IDLE: begin
        if (start) begin
          x      <= data_in;
          modulo <= modulo_in;
        end
      end
      SQUARE: begin
        if (mul.ready) begin
          x2   <= mul.product;
          term <= x;
          sum  <= x;
        end
      end
      MULTIPLY: if (mul.ready) term <= mul.product;
      DIVIDE: if (div.ready) term <= div.quotient;
      // Wraparound add
      ACCUMULATE: sum <= sum + term;
      REDUCE: if (div.ready) data_out <= div.remainder;
      default: ;
    endcase
  end

  // Operand steering by phase
  assign mul.multiplicand = (state == SQUARE) ? x : term;
  assign mul.multiplier   = (state == SQUARE) ? x : x2;
  assign div.dividend     = (state == REDUCE) ? sum : term;
  assign div.divisor      = (state == REDUCE) ? modulo : series_div;

  assign ready = (state == DONE);

  // Vector controller waits for ready before the next element
  a_start_in_idle: assert property (@(posedge CLK) disable iff (RST)
    start |-> (state == IDLE))
    else $error("scalar start while busy");

endmodule

`default_nettype wire

// File: hw/ntm_vector_sinh_function.sv
`timescale 1ns/10ps
`default_nettype none

module ntm_vector_sinh_function
  import ntm_fixed_pkg::*;
  import ntm_ctrl_pkg::*;
#(
  parameter int DATA_SIZE = DEFAULT_DATA_SIZE
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  output logic                 ready,
  input  logic                 data_in_enable,
  output logic                 data_out_enable,
  input  logic [DATA_SIZE-1:0] size_in,
  input  logic [DATA_SIZE-1:0] modulo_in,
  input  logic [DATA_SIZE-1:0] data_in,
  output logic [DATA_SIZE-1:0] data_out,
  output logic                 scalar_start,
  input  logic                 scalar_ready,
  output logic [DATA_SIZE-1:0] scalar_modulo,
  output logic [DATA_SIZE-1:0] scalar_data,
  input  logic [DATA_SIZE-1:0] scalar_result
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  vector_state_t        state;
  logic [DATA_SIZE-1:0] index;
  // Vector length held for the whole run
  logic [DATA_SIZE-1:0] size;

  ////////////////////////////////////////
  // Element loop
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= STARTER;
      index           <= '0;
      size            <= '0;
      ready           <= 1'b0;
      data_out_enable <= 1'b0;
      scalar_start    <= 1'b0;
      data_out        <= '0;
    end else begin
      // All strobes are one cycle
      ready           <= 1'b0;
      data_out_enable <= 1'b0;
      scalar_start    <= 1'b0;
      case (state)
        STARTER: begin
          if (start) begin
            size  <= size_in;
            index <= '0;
            state <= INPUT;
          end
        end
        INPUT: begin
          // Every element gets its own scalar run
          if (data_in_enable) begin
            scalar_start <= 1'b1;
            state        <= ENDER;
          end
        end
        ENDER: begin
          if (scalar_ready) begin
            data_out        <= scalar_result;
            data_out_enable <= 1'b1;
            if (index == size - 1'b1) begin
              // Last element so close the vector
              ready <= 1'b1;
              state <= STARTER;
            end else begin
              index <= index + 1'b1;
              state <= INPUT;
            end
          end
        end
        default: state <= STARTER;
      endcase
    end
  end

  // Element operands captured with the strobe
  always_ff @(posedge CLK) begin
    if (state == INPUT && data_in_enable) begin
      scalar_modulo <= modulo_in;
      scalar_data   <= data_in;
    end
  end

  // Zero length would never reach the last element
  a_size_nonzero: assert property (@(posedge CLK) disable iff (RST)
    (start && state == STARTER) |-> (size_in != '0))
    else $error("vector started with zero length");

endmodule

`default_nettype wire

// File: hw/ntm_sinh_top.sv
`timescale 1ns/10ps
`default_nettype none

module ntm_sinh_top #(
  parameter int DATA_SIZE    = 32,
  parameter int FRAC_SIZE    = 16,
  parameter int SERIES_TERMS = 4
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  input  logic [DATA_SIZE-1:0] size_in,
  input  logic [DATA_SIZE-1:0] modulo_in,
  input  logic [DATA_SIZE-1:0] data_in,
  input  logic                 data_in_enable,
  output logic                 ready,
  output logic                 data_out_enable,
  output logic [DATA_SIZE-1:0] data_out
);

  ////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////

  logic                 scalar_start;
  logic                 scalar_ready;
  logic [DATA_SIZE-1:0] scalar_modulo;
  logic [DATA_SIZE-1:0] scalar_data;
  logic [DATA_SIZE-1:0] scalar_result;

  // Shared arithmetic buses
  ntm_multiply_if #(.DATA_SIZE(DATA_SIZE)) mul_if ();
  ntm_divide_if   #(.DATA_SIZE(DATA_SIZE)) div_if ();

  ////////////////////////////////////////
  // Instances
  ////////////////////////////////////////

  ntm_vector_sinh_function #(
    .DATA_SIZE(DATA_SIZE)
  ) u_vector (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .ready          (ready),
    .data_in_enable (data_in_enable),
    .data_out_enable(data_out_enable),
    .size_in        (size_in),
    .modulo_in      (modulo_in),
    .data_in        (data_in),
    .data_out       (data_out),
    .scalar_start   (scalar_start),
    .scalar_ready   (scalar_ready),
    .scalar_modulo  (scalar_modulo),
    .scalar_data    (scalar_data),
    .scalar_result  (scalar_result)
  );

  ntm_scalar_sinh_function #(
    .DATA_SIZE   (DATA_SIZE),
    .FRAC_SIZE   (FRAC_SIZE),
    .SERIES_TERMS(SERIES_TERMS)
  ) u_scalar (
    .CLK      (CLK),
    .RST      (RST),
    .start    (scalar_start),
    .ready    (scalar_ready),
    .modulo_in(scalar_modulo),
    .data_in  (scalar_data),
    .data_out (scalar_result),
    .mul      (mul_if.requester),
    .div      (div_if.requester)
  );

  ntm_fixed_multiplier #(
    .DATA_SIZE(DATA_SIZE),
    .FRAC_SIZE(FRAC_SIZE)
  ) u_multiplier (
    .CLK(CLK),
    .RST(RST),
    .mul(mul_if.unit)
  );

  ntm_fixed_divider #(
    .DATA_SIZE(DATA_SIZE)
  ) u_divider (
    .CLK(CLK),
    .RST(RST),
    .div(div_if.unit)
  );

endmodule

`default_nettype wire

// File: test/ntm_sinh_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ntm_sinh_tb;

  localparam int DATA_SIZE    = 32;
  localparam int FRAC_SIZE    = 16;
  localparam int SERIES_TERMS = 4;
  localparam int NUM_RANDOM   = 6;
  // Inputs change this long after the rising edge
  localparam time DRIVE_DELAY = 10;
  // Scalar latency bound with square, mul and div per term, reduce and slack
  localparam int ELEM_CYCLES  = (2 * SERIES_TERMS + 1) * (DATA_SIZE + 1) + 64;

  logic                 CLK;
  logic                 RST;
  logic                 start;
  logic [DATA_SIZE-1:0] size_in;
  logic [DATA_SIZE-1:0] modulo_in;
  logic [DATA_SIZE-1:0] data_in;
  logic                 data_in_enable;
  logic                 ready;
  logic                 data_out_enable;
  logic [DATA_SIZE-1:0] data_out;

  ////////////////////////////////////////
  // Vector table
  ////////////////////////////////////////

  string                     name_q[$];
  int                        len_q[$];
  logic [DATA_SIZE-1:0]      mod_q[$];
  logic [3:0][DATA_SIZE-1:0] elem_q[$];
  logic [3:0][DATA_SIZE-1:0] exp_q[$];
  // Rows that also send strobes while busy
  bit                        noise_q[$];

  int errors;
  int checks;
  int out_pulses;
  int ready_pulses;
  int cycle_count;
  int cycle_limit;

  ntm_sinh_top #(
    .DATA_SIZE   (DATA_SIZE),
    .FRAC_SIZE   (FRAC_SIZE),
    .SERIES_TERMS(SERIES_TERMS)
  ) u_ntm_sinh_top (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .size_in        (size_in),
    .modulo_in      (modulo_in),
    .data_in        (data_in),
    .data_in_enable (data_in_enable),
    .ready          (ready),
    .data_out_enable(data_out_enable),
    .data_out       (data_out)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // Output strobes counted mid cycle
  always @(negedge CLK) begin
    if (data_out_enable) out_pulses++;
    if (ready) ready_pulses++;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Odd Taylor terms in fixed point then modulo
  function automatic logic [DATA_SIZE-1:0] sinh_mod_model(
    input logic [DATA_SIZE-1:0] x,
    input logic [DATA_SIZE-1:0] modulus
  );
    logic [2*DATA_SIZE-1:0] wide;
    logic [DATA_SIZE-1:0]   x2;
    logic [DATA_SIZE-1:0]   term;
    logic [DATA_SIZE-1:0]   sum;
    logic [DATA_SIZE-1:0]   denom;
    wide = {{DATA_SIZE{1'b0}}, x} * {{DATA_SIZE{1'b0}}, x};
    x2   = wide[FRAC_SIZE +: DATA_SIZE];
    term = x;
    sum  = x;
    for (int k = 1; k < SERIES_TERMS; k++) begin
      wide  = {{DATA_SIZE{1'b0}}, term} * {{DATA_SIZE{1'b0}}, x2};
      term  = wide[FRAC_SIZE +: DATA_SIZE];
      denom = DATA_SIZE'((2 * k) * (2 * k + 1));
      term  = term / denom;
      // Low word only
      sum   = sum + term;
    end
    return sum % modulus;
  endfunction

  task automatic add_row(input string name, input int len, input logic [DATA_SIZE-1:0] modulus,
                         input logic [3:0][DATA_SIZE-1:0] elems, input bit noise);
    logic [3:0][DATA_SIZE-1:0] expected;
    expected = '0;
    for (int i = 0; i < len; i++) begin
      expected[i] = sinh_mod_model(elems[i], modulus);
    end
    name_q.push_back(name);
    len_q.push_back(len);
    mod_q.push_back(modulus);
    elem_q.push_back(elems);
    exp_q.push_back(expected);
    noise_q.push_back(noise);
  endtask

  task automatic check_word(input string sig_name, input logic [DATA_SIZE-1:0] got,
                            input logic [DATA_SIZE-1:0] expected);
    checks++;
    assert (got === expected) else begin
      $display("ERR t=%0t %s got %h expected %h", $time, sig_name, got, expected);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // Vector driver
  ////////////////////////////////////////

  task automatic run_vector(input int idx);
    int                   n;
    int                   errs_before;
    int                   out_before;
    int                   rdy_before;
    logic [DATA_SIZE-1:0] modulus;
    n           = len_q[idx];
    modulus     = mod_q[idx];
    errs_before = errors;
    out_before  = out_pulses;
    rdy_before  = ready_pulses;
    @(posedge CLK);
    #DRIVE_DELAY;
    start     = 1'b1;
    size_in   = DATA_SIZE'(n);
    modulo_in = modulus;
    @(posedge CLK);
    #DRIVE_DELAY;
    start = 1'b0;
    for (int i = 0; i < n; i++) begin
      data_in        = elem_q[idx][i];
      data_in_enable = 1'b1;
      @(posedge CLK);
      #DRIVE_DELAY;
      data_in_enable = 1'b0;
      if (noise_q[idx]) begin
        // Stray strobes while the scalar unit runs
        repeat (3) @(posedge CLK);
        #DRIVE_DELAY;
        start          = 1'b1;
        data_in_enable = 1'b1;
        data_in        = 32'hdead_beef;
        @(posedge CLK);
        #DRIVE_DELAY;
        start          = 1'b0;
        data_in_enable = 1'b0;
      end
      @(negedge CLK);
      while (!data_out_enable) @(negedge CLK);
      check_word("data_out", data_out, exp_q[idx][i]);
      // Ready only with the last result
      check_word("ready", DATA_SIZE'(ready), DATA_SIZE'(i == n - 1));
      checks++;
      assert (data_out < modulus) else begin
        $display("ERR t=%0t data_out %h not below modulo_in %h", $time, data_out, modulus);
        errors++;
      end
      // Next element goes out in the usual drive slot
      @(posedge CLK);
      #DRIVE_DELAY;
    end
    repeat (3) @(posedge CLK);
    check_word("data_out_enable count", DATA_SIZE'(out_pulses - out_before), DATA_SIZE'(n));
    check_word("ready count", DATA_SIZE'(ready_pulses - rdy_before), DATA_SIZE'(1));
    $display("test %0d %s len %0d: %s", idx, name_q[idx], n,
             (errors == errs_before) ? "ok" : "mismatch");
  endtask

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////

  initial begin
    cycle_count = 0;
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("Timeout: no result after %0d cycles", cycle_count);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int                        total_elems;
    int                        rand_len;
    logic [DATA_SIZE-1:0]      rand_mod;
    logic [3:0][DATA_SIZE-1:0] rand_elems;
    RST            = 1'b1;
    start          = 1'b0;
    size_in        = '0;
    modulo_in      = '0;
    data_in        = '0;
    data_in_enable = 1'b0;
    errors         = 0;
    checks         = 0;
    out_pulses     = 0;
    ready_pulses   = 0;
    cycle_limit    = 0;
    void'($urandom(32'hcf90));

    // Elements listed last to first
    // 0x10000 is 1.0
    add_row("zero", 1, 32'hffff_ffff, {32'h0, 32'h0, 32'h0, 32'h0}, 1'b0);
    add_row("large mod", 4, 32'hffff_ffff,
            {32'h0001_8000, 32'h0000_4000, 32'h0001_0000, 32'h0000_8000}, 1'b0);
    add_row("large mod two", 2, 32'hffff_ffff, {32'h0, 32'h0, 32'h0000_0001, 32'h0002_0000}, 1'b0);
    add_row("small mod", 4, 32'd1000,
            {32'h0001_2345, 32'h0003_0000, 32'h0001_0000, 32'h0000_8000}, 1'b0);
    add_row("mod seven", 3, 32'd7, {32'h0, 32'h0002_8000, 32'h0000_c000, 32'h0001_0000}, 1'b0);
    add_row("busy strobes", 3, 32'd65521,
            {32'h0, 32'h0001_4000, 32'h0000_2000, 32'h0002_0000}, 1'b1);
    for (int r = 0; r < NUM_RANDOM; r++) begin
      rand_len = $urandom_range(4, 1);
      rand_mod = ($urandom % 2) ? DATA_SIZE'($urandom_range(60000, 2)) : 32'hffff_ffff;
      rand_elems = '0;
      for (int i = 0; i < rand_len; i++) begin
        rand_elems[i] = $urandom & 32'h0003_ffff;
      end
      add_row("random", rand_len, rand_mod, rand_elems, 1'b0);
    end

    total_elems = 0;
    foreach (len_q[i]) total_elems += len_q[i];
    cycle_limit = 100 + total_elems * ELEM_CYCLES + len_q.size() * 20;

    repeat (8) @(posedge CLK);
    #DRIVE_DELAY;
    RST = 1'b0;

    // Outputs quiet before any start
    repeat (5) begin
      @(negedge CLK);
      checks++;
      assert (!ready && !data_out_enable) else begin
        $display("Output strobe seen after reset before any start at t=%0t", $time);
        errors++;
      end
      check_word("data_out", data_out, '0);
    end

    foreach (len_q[i]) run_vector(i);

    $display("Vectors %0d, elements %0d, checks %0d, errors %0d",
             len_q.size(), total_elems, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ntm_sinh_top.f
hw/ntm_fixed_pkg.sv
hw/ntm_ctrl_pkg.sv
hw/ntm_arith_ifs.sv
hw/ntm_fixed_multiplier.sv
hw/ntm_fixed_divider.sv
hw/ntm_scalar_sinh_function.sv
hw/ntm_vector_sinh_function.sv
hw/ntm_sinh_top.sv
test/ntm_sinh_tb.sv

// File: Bender.yml
package:
  name: ntm_sinh

sources:
  - hw/ntm_fixed_pkg.sv
  - hw/ntm_ctrl_pkg.sv
  - hw/ntm_arith_ifs.sv
  - hw/ntm_fixed_multiplier.sv
  - hw/ntm_fixed_divider.sv
  - hw/ntm_scalar_sinh_function.sv
  - hw/ntm_vector_sinh_function.sv
  - hw/ntm_sinh_top.sv
  - target: test
    files:
      - test/ntm_sinh_tb.sv
